// File: flist.f
+incdir+hdl
+incdir+sim
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/inst_decoder.sv
hdl/register_file.sv
hdl/alu.sv
hdl/instruction_memory.sv
hdl/data_memory.sv
hdl/pipeline_top.sv
sim/tb_pipeline.sv

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
  input  pipe_pkg::alu_op_t op,
  input  pipe_pkg::word_t   a,
  input  pipe_pkg::word_t   b,
  input  isa_pkg::shamt_t   shamt,
  output pipe_pkg::word_t   y
);

  logic less; // signed compare for slt

  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      pipe_pkg::alu_add: y = a + b;
      pipe_pkg::alu_sub: y = a - b;
      pipe_pkg::alu_and: y = a & b;
      pipe_pkg::alu_or:  y = a | b;
      pipe_pkg::alu_slt: y = {31'b0, less};
      pipe_pkg::alu_sll: y = b << shamt; // rt shifted, as in MIPS
      default:           y = '0;
    endcase
  end

endmodule

// File: hdl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Instruction store, in 32-bit words
`define CORE_IMEM_AW    8
`define CORE_IMEM_DEPTH (1 << `CORE_IMEM_AW)

// Data store, in 32-bit words
`define CORE_DMEM_AW    6
`define CORE_DMEM_DEPTH (1 << `CORE_DMEM_AW)

// First fetch address after reset
`define CORE_RESET_PC   32'h0000_0000

`endif

// File: hdl/data_memory.sv
`timescale 1ns/1ps

`include "core_defines.svh"

module data_memory (
  input  logic            clk,
  input  logic            wr_en,
  input  pipe_pkg::word_t addr,
  input  pipe_pkg::word_t wr_data,
  output pipe_pkg::word_t rd_data
);

  pipe_pkg::word_t           mem [`CORE_DMEM_DEPTH];
  logic [`CORE_DMEM_AW-1:0]  word_idx;

  initial begin
    for (int i = 0; i < `CORE_DMEM_DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  assign word_idx = addr[`CORE_DMEM_AW+1:2]; // byte address to word index

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[word_idx] <= wr_data;
    end
  end

  assign rd_data = mem[word_idx];

  // Stores come from base plus offset in execute, so both must keep alignment
  assert property (@(posedge clk) wr_en |-> addr[1:0] == 2'b00);

endmodule

// File: hdl/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  pipe_pkg::word_t   instr,
  output isa_pkg::reg_idx_t rs,
  output isa_pkg::reg_idx_t rt,
  output isa_pkg::reg_idx_t dest,
  output isa_pkg::shamt_t   shamt,
  output pipe_pkg::word_t   imm_ext,
  output pipe_pkg::alu_op_t alu_op,
  output logic              use_imm,
  output logic              reg_write,
  output logic              mem_read,
  output logic              mem_write,
  output pipe_pkg::wb_src_t wb_src
);

  isa_pkg::opcode_t  opcode;
  isa_pkg::funct_t   funct;
  isa_pkg::imm16_t   imm;
  isa_pkg::reg_idx_t rd;
  logic              zero_ext;

  assign opcode = isa_pkg::opcode_t'(instr[31:26]);
  assign funct  = isa_pkg::funct_t'(instr[5:0]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign shamt  = instr[10:6];
  assign imm    = instr[15:0];

  always_comb begin
    alu_op    = pipe_pkg::alu_add; // also the address adder for lw/sw
    use_imm   = 1'b0;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    wb_src    = pipe_pkg::wb_alu;
    dest      = rt;
    zero_ext  = 1'b0;
    case (opcode)
      isa_pkg::op_r_type: begin
        dest      = rd;
        reg_write = 1'b1;
        case (funct)
          isa_pkg::fn_add: alu_op = pipe_pkg::alu_add;
          isa_pkg::fn_sub: alu_op = pipe_pkg::alu_sub;
          isa_pkg::fn_and: alu_op = pipe_pkg::alu_and;
          isa_pkg::fn_or:  alu_op = pipe_pkg::alu_or;
          isa_pkg::fn_slt: alu_op = pipe_pkg::alu_slt;
          isa_pkg::fn_sll: alu_op = pipe_pkg::alu_sll;
          default:         reg_write = 1'b0; // unknown funct is a no-op
        endcase
      end
      isa_pkg::op_addi: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
      end
      isa_pkg::op_andi: begin
        alu_op    = pipe_pkg::alu_and;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        zero_ext  = 1'b1; // logical immediates are unsigned
      end
      isa_pkg::op_ori: begin
        alu_op    = pipe_pkg::alu_or;
        use_imm   = 1'b1;
        reg_write = 1'b1;
        zero_ext  = 1'b1;
      end
      isa_pkg::op_lui: begin
        reg_write = 1'b1;
        wb_src    = pipe_pkg::wb_upper_imm;
      end
      isa_pkg::op_lw: begin
        use_imm   = 1'b1;
        reg_write = 1'b1;
        mem_read  = 1'b1;
        wb_src    = pipe_pkg::wb_mem;
      end
      isa_pkg::op_sw: begin
        use_imm   = 1'b1;
        mem_write = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign imm_ext = zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};

endmodule

// File: hdl/instruction_memory.sv
`timescale 1ns/1ps

`include "core_defines.svh"

module instruction_memory (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [`CORE_IMEM_AW-1:0] wr_addr,
  input  pipe_pkg::word_t          wr_data,
  input  pipe_pkg::word_t          rd_addr,
  output pipe_pkg::word_t          rd_data
);

  pipe_pkg::word_t mem [`CORE_IMEM_DEPTH];
  logic            in_range;

  initial begin
    for (int i = 0; i < `CORE_IMEM_DEPTH; i++) begin
      mem[i] = '0; // all-zero word is a no-op
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  assign in_range = (rd_addr[31:`CORE_IMEM_AW+2] == '0);
  assign rd_data  = in_range ? mem[rd_addr[`CORE_IMEM_AW+1:2]] : '0;

endmodule

// File: hdl/isa_pkg.sv
package isa_pkg;

  // Instruction field widths
  typedef logic [4:0]  reg_idx_t;
  typedef logic [15:0] imm16_t;
  typedef logic [4:0]  shamt_t;

  // Major opcodes, bits 31:26
  typedef enum logic [5:0] {
    op_r_type = 6'h00,
    op_addi   = 6'h08,
    op_andi   = 6'h0c,
    op_ori    = 6'h0d,
    op_lui    = 6'h0f,
    op_lw     = 6'h23,
    op_sw     = 6'h2b
  } opcode_t;

  // R-type function codes, bits 5:0
  typedef enum logic [5:0] {
    fn_sll = 6'h00,
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_or  = 6'h25,
    fn_slt = 6'h2a
  } funct_t;

endpackage

// File: hdl/pipe_pkg.sv
package pipe_pkg;

  // Data word or byte address
  typedef logic [31:0] word_t;

  // Operation selected for the execute stage
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_slt = 3'd4,
    alu_sll = 3'd5
  } alu_op_t;

  // Where the writeback value comes from
  typedef enum logic [1:0] {
    wb_alu       = 2'd0,
    wb_mem       = 2'd1,
    wb_upper_imm = 2'd2
  } wb_src_t;

endpackage

// File: hdl/pipeline_top.sv
`timescale 1ns/1ps

`include "core_defines.svh"

module pipeline_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     run,
  input  logic                     load_en,
  input  logic [`CORE_IMEM_AW-1:0] load_addr,
  input  pipe_pkg::word_t          load_data,
  output logic                     wb_valid,
  output isa_pkg::reg_idx_t        wb_reg,
  output pipe_pkg::word_t          wb_data,
  output logic                     st_valid,
  output pipe_pkg::word_t          st_addr,
  output pipe_pkg::word_t          st_data
);

  pipe_pkg::word_t   pc, imem_rd_data;
  logic              ifid_valid;
  pipe_pkg::word_t   ifid_instr;

  isa_pkg::reg_idx_t id_rs, id_rt, id_dest;
  isa_pkg::shamt_t   id_shamt;
  pipe_pkg::word_t   id_imm_ext, id_rs_data, id_rt_data;
  pipe_pkg::alu_op_t id_alu_op;
  logic              id_use_imm, id_reg_write, id_mem_read, id_mem_write;
  pipe_pkg::wb_src_t id_wb_src;

  logic              idex_valid, idex_use_imm, idex_reg_write, idex_mem_read, idex_mem_write;
  pipe_pkg::word_t   idex_rs_data, idex_rt_data, idex_imm_ext;
  isa_pkg::shamt_t   idex_shamt;
  isa_pkg::reg_idx_t idex_dest;
  pipe_pkg::alu_op_t idex_alu_op;
  pipe_pkg::wb_src_t idex_wb_src;
  pipe_pkg::word_t   ex_b, ex_y;

  logic              exmem_valid, exmem_reg_write, exmem_mem_read, exmem_mem_write;
  pipe_pkg::word_t   exmem_alu_y, exmem_rt_data, dmem_rd_data;
  isa_pkg::imm16_t   exmem_imm;
  isa_pkg::reg_idx_t exmem_dest;
  pipe_pkg::wb_src_t exmem_wb_src;

  logic              memwb_valid, memwb_reg_write, rf_wr_en;
  pipe_pkg::word_t   memwb_alu_y, memwb_mem_data, wb_value;
  isa_pkg::imm16_t   memwb_imm;
  isa_pkg::reg_idx_t memwb_dest;
  pipe_pkg::wb_src_t memwb_wb_src;

  // Fetch. PC holds while run is low so the pipe can drain
  always_ff @(posedge clk) begin
    if (rst) pc <= `CORE_RESET_PC;
    else if (run) pc <= pc + 32'd4;
  end

  instruction_memory u_imem (
    .clk(clk), .wr_en(load_en), .wr_addr(load_addr), .wr_data(load_data),
    .rd_addr(pc), .rd_data(imem_rd_data)
  );

  always_ff @(posedge clk) begin
    if (rst) ifid_valid <= 1'b0;
    else ifid_valid <= run; // bubble when idle
    ifid_instr <= imem_rd_data;
  end

  // Decode and register read
  inst_decoder u_dec (
    .instr(ifid_instr), .rs(id_rs), .rt(id_rt), .dest(id_dest), .shamt(id_shamt),
    .imm_ext(id_imm_ext), .alu_op(id_alu_op), .use_imm(id_use_imm),
    .reg_write(id_reg_write), .mem_read(id_mem_read), .mem_write(id_mem_write),
    .wb_src(id_wb_src)
  );

  register_file u_rf (
    .clk(clk), .rst(rst), .rd_a(id_rs), .rd_b(id_rt), .wr_en(rf_wr_en),
    .wr_reg(memwb_dest), .wr_data(wb_value), .rd_a_data(id_rs_data), .rd_b_data(id_rt_data)
  );

  always_ff @(posedge clk) begin
    if (rst) idex_valid <= 1'b0;
    else idex_valid <= ifid_valid;
    idex_rs_data   <= id_rs_data;
    idex_rt_data   <= id_rt_data;
    idex_imm_ext   <= id_imm_ext;
    idex_shamt     <= id_shamt;
    idex_dest      <= id_dest;
    idex_alu_op    <= id_alu_op;
    idex_use_imm   <= id_use_imm;
    idex_reg_write <= id_reg_write;
    idex_mem_read  <= id_mem_read;
    idex_mem_write <= id_mem_write;
    idex_wb_src    <= id_wb_src;
  end

  // Execute
  assign ex_b = idex_use_imm ? idex_imm_ext : idex_rt_data;

  alu u_alu (.op(idex_alu_op), .a(idex_rs_data), .b(ex_b), .shamt(idex_shamt), .y(ex_y));

  always_ff @(posedge clk) begin
    if (rst) exmem_valid <= 1'b0;
    else exmem_valid <= idex_valid;
    exmem_alu_y     <= ex_y;
    exmem_rt_data   <= idex_rt_data; // store data
    exmem_imm       <= idex_imm_ext[15:0];
    exmem_dest      <= idex_dest;
    exmem_reg_write <= idex_reg_write;
    exmem_mem_read  <= idex_mem_read;
    exmem_mem_write <= idex_mem_write;
    exmem_wb_src    <= idex_wb_src;
  end

  // Memory
  assign st_valid = exmem_valid && exmem_mem_write;
  assign st_addr  = exmem_alu_y;
  assign st_data  = exmem_rt_data;

  data_memory u_dmem (
    .clk(clk), .wr_en(st_valid), .addr(exmem_alu_y), .wr_data(exmem_rt_data),
    .rd_data(dmem_rd_data)
  );

  always_ff @(posedge clk) begin
    if (rst) memwb_valid <= 1'b0;
    else memwb_valid <= exmem_valid;
    memwb_alu_y     <= exmem_alu_y;
    memwb_mem_data  <= exmem_mem_read ? dmem_rd_data : '0; // only loads capture
    memwb_imm       <= exmem_imm;
    memwb_dest      <= exmem_dest;
    memwb_reg_write <= exmem_reg_write;
    memwb_wb_src    <= exmem_wb_src;
  end

  // Writeback
  always_comb begin
    case (memwb_wb_src)
      pipe_pkg::wb_mem:       wb_value = memwb_mem_data;
      pipe_pkg::wb_upper_imm: wb_value = {memwb_imm, 16'h0000};
      default:                wb_value = memwb_alu_y;
    endcase
  end

  assign rf_wr_en = memwb_valid && memwb_reg_write;
  assign wb_valid = rf_wr_en && memwb_dest != '0; // r0 writes are silent
  assign wb_reg   = memwb_dest;
  assign wb_data  = wb_value;

  // Program loading only while the core is idle
  assert property (@(posedge clk) disable iff (rst) !(load_en && run));

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic              clk,
  input  logic              rst,
  input  isa_pkg::reg_idx_t rd_a,
  input  isa_pkg::reg_idx_t rd_b,
  input  logic              wr_en,
  input  isa_pkg::reg_idx_t wr_reg,
  input  pipe_pkg::word_t   wr_data,
  output pipe_pkg::word_t   rd_a_data,
  output pipe_pkg::word_t   rd_b_data
);

  pipe_pkg::word_t regs [32]; // r0 cleared by reset, never written

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_reg != '0) begin
      regs[wr_reg] <= wr_data;
    end
  end

  // Same-cycle write shows through to the read side
  function automatic pipe_pkg::word_t read_port(isa_pkg::reg_idx_t idx);
    if (wr_en && wr_reg != '0 && wr_reg == idx) return wr_data;
    return regs[idx];
  endfunction

  always_comb begin
    rd_a_data = read_port(rd_a);
    rd_b_data = read_port(rd_b);
  end

  // Register zero reads as zero whatever was aimed at it
  assert property (@(posedge clk) disable iff (rst)
    (rd_a != '0 || rd_a_data == '0) && (rd_b != '0 || rd_b_data == '0));

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_pipeline -f flist.f \
  && ./obj_dir/Vtb_pipeline | tee /dev/stderr | grep -q "Test passed" \
  && exit 0 || exit 1

// File: sim/tb_isa_model.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// In-order reference for the generated program
pipe_pkg::word_t   model_regs [32];
pipe_pkg::word_t   model_dmem [`CORE_DMEM_DEPTH];
logic              model_stored [`CORE_DMEM_DEPTH]; // word written by an earlier sw
isa_pkg::reg_idx_t exp_wb_reg_q [$];
pipe_pkg::word_t   exp_wb_data_q [$];
pipe_pkg::word_t   exp_st_addr_q [$];
pipe_pkg::word_t   exp_st_data_q [$];
int                zero_dest_count;
int                load_hit_count;

task automatic run_model();
  pipe_pkg::word_t          ins;
  pipe_pkg::word_t          a;
  pipe_pkg::word_t          b;
  pipe_pkg::word_t          val;
  pipe_pkg::word_t          addr;
  pipe_pkg::word_t          sext;
  pipe_pkg::word_t          zext;
  isa_pkg::reg_idx_t        dest;
  isa_pkg::shamt_t          sh;
  logic [`CORE_DMEM_AW-1:0] widx;
  logic                     writes;
  for (int r = 0; r < 32; r++) begin
    model_regs[r] = '0;
  end
  for (int w = 0; w < `CORE_DMEM_DEPTH; w++) begin
    model_dmem[w]   = '0;
    model_stored[w] = 1'b0;
  end
  zero_dest_count = 0;
  load_hit_count  = 0;
  for (int i = 0; i < PROG_LEN; i++) begin
    ins    = prog[i];
    a      = model_regs[ins[25:21]];
    b      = model_regs[ins[20:16]];
    sh     = ins[10:6];
    sext   = {{16{ins[15]}}, ins[15:0]};
    zext   = {16'h0000, ins[15:0]};
    addr   = a + sext;
    widx   = addr[`CORE_DMEM_AW+1:2]; // word index of a byte address
    dest   = ins[20:16];
    val    = '0;
    writes = 1'b1;
    case (ins[31:26])
      isa_pkg::op_r_type: begin
        dest = ins[15:11];
        case (ins[5:0])
          isa_pkg::fn_add: val = a + b;
          isa_pkg::fn_sub: val = a - b;
          isa_pkg::fn_and: val = a & b;
          isa_pkg::fn_or:  val = a | b;
          isa_pkg::fn_slt: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          isa_pkg::fn_sll: val = b << sh;
          default:         writes = 1'b0;
        endcase
      end
      isa_pkg::op_addi: val = a + sext;
      isa_pkg::op_andi: val = a & zext;
      isa_pkg::op_ori:  val = a | zext;
      isa_pkg::op_lui:  val = {ins[15:0], 16'h0000};
      isa_pkg::op_lw: begin
        val = model_dmem[widx];
        if (model_stored[widx]) load_hit_count++;
      end
      isa_pkg::op_sw: begin
        writes             = 1'b0;
        model_dmem[widx]   = b;
        model_stored[widx] = 1'b1;
        exp_st_addr_q.push_back(addr);
        exp_st_data_q.push_back(b);
      end
      default: writes = 1'b0;
    endcase
    if (writes && dest == '0) zero_dest_count++; // result dropped, no pulse
    if (writes && dest != '0) begin
      model_regs[dest] = val;
      exp_wb_reg_q.push_back(dest);
      exp_wb_data_q.push_back(val);
    end
  end
endtask

`endif

// File: sim/tb_pipeline.sv
`timescale 1ns/1ps

`include "core_defines.svh"

module tb_pipeline;

  localparam int PROG_LEN   = 120;
  localparam int IDLE_LIMIT = 16; // cycles without a new event before giving up

  logic                     clk;
  logic                     rst;
  logic                     run;
  logic                     load_en;
  logic [`CORE_IMEM_AW-1:0] load_addr;
  pipe_pkg::word_t          load_data;
  logic                     wb_valid;
  isa_pkg::reg_idx_t        wb_reg;
  pipe_pkg::word_t          wb_data;
  logic                     st_valid;
  pipe_pkg::word_t          st_addr;
  pipe_pkg::word_t          st_data;

  pipe_pkg::word_t prog [PROG_LEN];
  int              last_write [32]; // newest writer of each register
  logic [31:0]     lcg_state;
  logic            monitor_on;
  int              wb_checked;
  int              st_checked;
  int              wb_errors;
  int              st_errors;
  int              extra_events;
  int              tests_ok;
  int              tests_bad;

  `include "tb_isa_model.svh"

  pipeline_top dut (
    .clk(clk), .rst(rst), .run(run), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
    .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:8]) % n; // upper bits are the better ones
  endfunction

  // Source must have been written three or more instructions back
  function automatic isa_pkg::reg_idx_t pick_src(input int idx);
    int r;
    if (rand_below(8) == 0) return 5'd0;
    for (int tries = 0; tries < 64; tries++) begin
      r = rand_below(31) + 1;
      if (idx - last_write[r] >= 3) return isa_pkg::reg_idx_t'(r);
    end
    return 5'd0;
  endfunction

  function automatic isa_pkg::reg_idx_t pick_dest();
    if (rand_below(8) == 0) return 5'd0; // discarded write
    return isa_pkg::reg_idx_t'(rand_below(31) + 1);
  endfunction

  function automatic pipe_pkg::word_t enc_r(input isa_pkg::funct_t fn,
      input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt,
      input isa_pkg::reg_idx_t rd, input isa_pkg::shamt_t sh);
    return {isa_pkg::op_r_type, rs, rt, rd, sh, fn};
  endfunction

  function automatic pipe_pkg::word_t enc_i(input isa_pkg::opcode_t op,
      input isa_pkg::reg_idx_t rs, input isa_pkg::reg_idx_t rt, input isa_pkg::imm16_t imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic build_program();
    int                kind;
    logic [31:0]       r;
    isa_pkg::reg_idx_t rs;
    isa_pkg::reg_idx_t rt;
    isa_pkg::reg_idx_t rd;
    for (int k = 0; k < 32; k++) begin
      last_write[k] = -8;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      kind = rand_below(13);
      r    = next_rand();
      rs   = pick_src(i);
      rt   = pick_src(i);
      rd   = pick_dest();
      case (kind)
        0:  prog[i] = enc_r(isa_pkg::fn_add, rs, rt, rd, 5'd0);
        1:  prog[i] = enc_r(isa_pkg::fn_sub, rs, rt, rd, 5'd0);
        2:  prog[i] = enc_r(isa_pkg::fn_and, rs, rt, rd, 5'd0);
        3:  prog[i] = enc_r(isa_pkg::fn_or, rs, rt, rd, 5'd0);
        4:  prog[i] = enc_r(isa_pkg::fn_slt, rs, rt, rd, 5'd0);
        5:  prog[i] = enc_r(isa_pkg::fn_sll, 5'd0, rt, rd, r[15:11]);
        6:  prog[i] = enc_i(isa_pkg::op_addi, rs, rd, r[31:16]);
        7:  prog[i] = enc_i(isa_pkg::op_andi, rs, rd, r[31:16]);
        8:  prog[i] = enc_i(isa_pkg::op_ori, rs, rd, r[31:16]);
        9:  prog[i] = enc_i(isa_pkg::op_lui, 5'd0, rd, r[31:16]);
        // 16 words only, so loads often hit an earlier store
        10: prog[i] = enc_i(isa_pkg::op_lw, 5'd0, rd, isa_pkg::imm16_t'(rand_below(16) * 4));
        11: prog[i] = enc_i(isa_pkg::op_sw, 5'd0, rt, isa_pkg::imm16_t'(rand_below(16) * 4));
        default: prog[i] = 32'h0000_0000;
      endcase
      if (kind <= 10 && rd != '0) last_write[rd] = i;
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_wb(input isa_pkg::reg_idx_t got_reg, input pipe_pkg::word_t got_data);
    isa_pkg::reg_idx_t want_reg;
    pipe_pkg::word_t   want_data;
    if (exp_wb_reg_q.size() == 0) begin
      $display("Writeback to register %0d arrived when none was expected", got_reg);
      extra_events++;
    end else begin
      want_reg  = exp_wb_reg_q.pop_front();
      want_data = exp_wb_data_q.pop_front();
      wb_checked++;
      if (got_reg !== want_reg) begin
        $display("Error: wb_reg got 0x%02h expected 0x%02h", got_reg, want_reg);
        wb_errors++;
      end
      if (got_data !== want_data) begin
        $display("Error: wb_data got 0x%08h expected 0x%08h", got_data, want_data);
        wb_errors++;
      end
    end
  endtask

  task automatic check_store(input pipe_pkg::word_t got_addr, input pipe_pkg::word_t got_data);
    pipe_pkg::word_t want_addr;
    pipe_pkg::word_t want_data;
    if (exp_st_addr_q.size() == 0) begin
      $display("Store to address 0x%08h arrived when none was expected", got_addr);
      extra_events++;
    end else begin
      want_addr = exp_st_addr_q.pop_front();
      want_data = exp_st_data_q.pop_front();
      st_checked++;
      if (got_addr !== want_addr) begin
        $display("Error: st_addr got 0x%08h expected 0x%08h", got_addr, want_addr);
        st_errors++;
      end
      if (got_data !== want_data) begin
        $display("Error: st_data got 0x%08h expected 0x%08h", got_data, want_data);
        st_errors++;
      end
    end
  endtask

  function automatic int outstanding();
    return exp_wb_reg_q.size() + exp_st_addr_q.size();
  endfunction

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("%s: ok", name);
      tests_ok++;
    end else begin
      $display("%s: %0d error(s)", name, errs);
      tests_bad++;
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (monitor_on) begin
      if (wb_valid) check_wb(wb_reg, wb_data);
      if (st_valid) check_store(st_addr, st_data);
    end
  end

  initial begin
    int idle_errs;
    int idle_cycles;
    int prev_left;
    lcg_state    = 32'ha8c73325;
    rst          = 1'b1;
    run          = 1'b0;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    monitor_on   = 1'b0;
    wb_checked   = 0;
    st_checked   = 0;
    wb_errors    = 0;
    st_errors    = 0;
    extra_events = 0;
    tests_ok     = 0;
    tests_bad    = 0;
    idle_errs    = 0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    build_program();
    run_model();
    for (int i = 0; i < PROG_LEN; i++) begin
      step();
      load_en   = 1'b1;
      load_addr = i[`CORE_IMEM_AW-1:0];
      load_data = prog[i];
    end
    step();
    load_en = 1'b0;

    // Program sits at the fetch address, but with run low nothing may retire
    for (int c = 0; c < 20; c++) begin
      @(negedge clk);
      if (wb_valid !== 1'b0 || st_valid !== 1'b0) begin
        $display("A valid output pulsed while the core sat idle, cycle %0d", c);
        idle_errs++;
      end
    end
    report_test("idle_after_reset", idle_errs);

    step();
    monitor_on = 1'b1;
    run        = 1'b1;
    repeat (PROG_LEN) @(posedge clk); // one fetch per edge
    #1;
    run = 1'b0;

    // Drain, each event gets its own idle budget
    idle_cycles = 0;
    prev_left   = outstanding();
    while (outstanding() != 0 && idle_cycles < IDLE_LIMIT) begin
      @(posedge clk);
      if (outstanding() < prev_left) begin
        prev_left   = outstanding();
        idle_cycles = 0;
      end else begin
        idle_cycles++;
      end
    end
    if (outstanding() != 0) begin
      $display("Timed out with %0d expected events still missing", outstanding());
    end
    report_test("all_events_arrived", outstanding());
    repeat (10) @(posedge clk); // room for stray pulses

    $display("%0d writebacks and %0d stores compared, %0d r0 writes, %0d loads after a store",
             wb_checked, st_checked, zero_dest_count, load_hit_count);
    report_test("writebacks_match", wb_errors + ((wb_checked == 0) ? 1 : 0));
    report_test("stores_match", st_errors + ((st_checked == 0) ? 1 : 0));
    report_test("no_unexpected_events", extra_events);

    $display("Summary: %0d tests ok, %0d tests failing", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
